//--- common/vdp_defines.svh
// Video raster sizes, interrupt width and CPU port addresses
`ifndef VDP_DEFINES_SVH
`define VDP_DEFINES_SVH

// Counter wrap values, pixels per line and lines per frame
`define VDP_H_TOTAL 448
`define VDP_V_TOTAL 320

// Visible window starting at the origin
`define VDP_H_ACTIVE 256
`define VDP_V_ACTIVE 192

// Frame interrupt width in pixel cycles
`define VDP_INT_LEN 32

// ========================================
// CPU port addresses
// ========================================
// Low byte of the extended register window, high byte is the index
`define VDP_PORT_EXT 8'hAF
// Legacy border port, decoded on the low byte only
`define VDP_PORT_ZBORDER 8'hFE
// Legacy page port, full address
`define VDP_PORT_ZPAGE 16'h7FFD

`endif

//--- common/vdp_pkg.sv
// Video register package with register indices, video modes and the shared bus structs
`default_nettype none

package vdp_pkg;

    // ========================================
    // Extended register window indices
    // ========================================
    typedef enum logic [7:0] {
        VCONF    = 8'h00,
        VPAGE    = 8'h01,
        GXOFFSL  = 8'h02,
        GXOFFSH  = 8'h03,
        GYOFFSL  = 8'h04,
        GYOFFSH  = 8'h05,
        TSCONF   = 8'h06,
        PALSEL   = 8'h07,
        BORDER   = 8'h0F,
        TMPAGE   = 8'h16,
        T0GPAGE  = 8'h17,
        T1GPAGE  = 8'h18,
        SGPAGE   = 8'h19,
        HINTBEG  = 8'h22,
        VINTBEGL = 8'h23,
        VINTBEGH = 8'h24,
        T0XOFFSL = 8'h40,
        T0XOFFSH = 8'h41,
        T0YOFFSL = 8'h42,
        T0YOFFSH = 8'h43,
        T1XOFFSL = 8'h44,
        T1XOFFSH = 8'h45,
        T1YOFFSL = 8'h46,
        T1YOFFSH = 8'h47,
        // Internal codes for the legacy ports, never reachable through the window
        ZBORDER  = 8'hF0,
        ZVPAGE   = 8'hF1
    } vdp_reg_e;

    // Video mode held in vconf bits 1:0
    typedef enum logic [1:0] {
        ZX     = 2'd0,
        COL16  = 2'd1,
        COL256 = 2'd2,
        TEXT   = 2'd3
    } vdp_mode_e;

    // ========================================
    // Bus and pipeline structs
    // ========================================
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
    } cpu_wr_t;

    typedef struct packed {
        logic        en;
        vdp_reg_e    sel;
        logic [7:0]  data;
    } reg_wr_t;

    typedef struct packed {
        logic [7:0] border;
        logic [7:0] vpage;
        logic [7:0] vconf;
        logic [7:0] tsconf;
        logic [7:0] palsel;
        logic [7:0] tmpage;
        logic [7:0] t0gpage;
        logic [7:0] t1gpage;
        logic [7:0] sgpage;
        logic [7:0] hint_beg;
        logic [8:0] gx_offs;
        logic [8:0] gy_offs;
        logic [8:0] t0x_offs;
        logic [8:0] t0y_offs;
        logic [8:0] t1x_offs;
        logic [8:0] t1y_offs;
        logic [8:0] vint_beg;
    } video_regs_t;

    typedef struct packed {
        logic [8:0] hcnt;
        logic [8:0] vcnt;
        logic       active;
    } raster_pos_t;

    typedef struct packed {
        logic [7:0] page;
        logic [8:0] x;
        logic [8:0] y;
    } layer_fetch_t;

    typedef struct packed {
        logic         active;
        logic [7:0]   border_col;
        vdp_mode_e    mode;
        layer_fetch_t gfx;
        logic         tile_en;
        layer_fetch_t tile;
    } pix_req_t;

endpackage

`default_nettype wire

//--- verilog/port_bridge.sv
// CPU port bridge, four-phase req/ack slave that turns a port write into one register write
`timescale 1ns/1ps
`default_nettype none

`include "vdp_defines.svh"

module port_bridge (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             cpu_req,
    input  wire vdp_pkg::cpu_wr_t cpu,
    output logic                  cpu_ack,
    output vdp_pkg::reg_wr_t      reg_wr
);

    typedef enum logic {
        IDLE,
        ACK
    } state_t;

    state_t state;
    // High in the cycle reg_wr is issued, ack follows one cycle later
    logic   wr_pend;

    // Map a CPU port address onto a register select, en low when nothing is hit
    function automatic vdp_pkg::reg_wr_t decode(input vdp_pkg::cpu_wr_t wr);
        vdp_pkg::reg_wr_t res;
        res.en   = 1'b0;
        res.sel  = vdp_pkg::ZBORDER;
        res.data = wr.data;
        if (wr.addr[7:0] == `VDP_PORT_EXT)
        begin
            case (wr.addr[15:8])
                vdp_pkg::VCONF,    vdp_pkg::VPAGE,
                vdp_pkg::GXOFFSL,  vdp_pkg::GXOFFSH,
                vdp_pkg::GYOFFSL,  vdp_pkg::GYOFFSH,
                vdp_pkg::TSCONF,   vdp_pkg::PALSEL,
                vdp_pkg::BORDER,   vdp_pkg::TMPAGE,
                vdp_pkg::T0GPAGE,  vdp_pkg::T1GPAGE,
                vdp_pkg::SGPAGE,   vdp_pkg::HINTBEG,
                vdp_pkg::VINTBEGL, vdp_pkg::VINTBEGH,
                vdp_pkg::T0XOFFSL, vdp_pkg::T0XOFFSH,
                vdp_pkg::T0YOFFSL, vdp_pkg::T0YOFFSH,
                vdp_pkg::T1XOFFSL, vdp_pkg::T1XOFFSH,
                vdp_pkg::T1YOFFSL, vdp_pkg::T1YOFFSH:
                begin
                    res.en  = 1'b1;
                    res.sel = vdp_pkg::vdp_reg_e'(wr.addr[15:8]);
                end
                default:
                begin
                    res.en = 1'b0;
                end
            endcase
        end
        else if (wr.addr == `VDP_PORT_ZPAGE)
        begin
            res.en  = 1'b1;
            res.sel = vdp_pkg::ZVPAGE;
        end
        else if (wr.addr[7:0] == `VDP_PORT_ZBORDER)
        begin
            res.en  = 1'b1;
            res.sel = vdp_pkg::ZBORDER;
        end
        return res;
    endfunction

    // Ack is high for the whole ACK state
    assign cpu_ack = (state == ACK);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= IDLE;
            wr_pend <= 1'b0;
            reg_wr  <= '0;
        end
        else
        begin
            reg_wr.en <= 1'b0;
            wr_pend   <= 1'b0;
            case (state)
                IDLE:
                    if (cpu_req)
                    begin
                        // Ack rises once the register bank holds the new value
                        if (wr_pend)
                            state <= ACK;
                        else
                        begin
                            wr_pend <= 1'b1;
                            reg_wr  <= decode(cpu);
                        end
                    end
                ACK:
                    // Wait for the CPU to drop req before closing the cycle
                    if (!cpu_req)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(cpu_ack) |-> $past(cpu_req));

    a_wr_single_pulse: assert property (@(posedge clk) disable iff (reset)
        reg_wr.en |=> !reg_wr.en);

endmodule

`default_nettype wire

//--- video_ports/video_ports.sv
// Video register bank holding every parameter written by the CPU, with power-on defaults
`timescale 1ns/1ps
`default_nettype none

module video_ports (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire vdp_pkg::reg_wr_t reg_wr,
    output vdp_pkg::video_regs_t  regs
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            regs.border   <= 8'h00;
            regs.vpage    <= 8'h05;
            regs.vconf    <= 8'h00;
            regs.tsconf   <= 8'h00;
            regs.palsel   <= 8'h0F;
            regs.tmpage   <= 8'h00;
            regs.t0gpage  <= 8'h00;
            regs.t1gpage  <= 8'h00;
            regs.sgpage   <= 8'h00;
            // Line interrupt defaults to pixel 4 of the line
            regs.hint_beg <= 8'd2;
            regs.gx_offs  <= 9'd0;
            regs.gy_offs  <= 9'd0;
            regs.t0x_offs <= 9'd0;
            regs.t0y_offs <= 9'd0;
            regs.t1x_offs <= 9'd0;
            regs.t1y_offs <= 9'd0;
            regs.vint_beg <= 9'd0;
        end
        else if (reg_wr.en)
        begin
            case (reg_wr.sel)
                // Legacy ports force the upper bits
                vdp_pkg::ZBORDER:  regs.border        <= {5'b11110, reg_wr.data[2:0]};
                vdp_pkg::ZVPAGE:   regs.vpage         <= {6'b000001, reg_wr.data[3], 1'b1};

                vdp_pkg::BORDER:   regs.border        <= reg_wr.data;
                vdp_pkg::VPAGE:    regs.vpage         <= reg_wr.data;
                vdp_pkg::VCONF:    regs.vconf         <= reg_wr.data;
                vdp_pkg::TSCONF:   regs.tsconf        <= reg_wr.data;
                vdp_pkg::PALSEL:   regs.palsel        <= reg_wr.data;
                vdp_pkg::TMPAGE:   regs.tmpage        <= reg_wr.data;
                vdp_pkg::T0GPAGE:  regs.t0gpage       <= reg_wr.data;
                vdp_pkg::T1GPAGE:  regs.t1gpage       <= reg_wr.data;
                vdp_pkg::SGPAGE:   regs.sgpage        <= reg_wr.data;
                vdp_pkg::HINTBEG:  regs.hint_beg      <= reg_wr.data;

                // 9-bit fields take the low byte and then bit 0 of the high byte
                vdp_pkg::GXOFFSL:  regs.gx_offs[7:0]  <= reg_wr.data;
                vdp_pkg::GXOFFSH:  regs.gx_offs[8]    <= reg_wr.data[0];
                vdp_pkg::GYOFFSL:  regs.gy_offs[7:0]  <= reg_wr.data;
                vdp_pkg::GYOFFSH:  regs.gy_offs[8]    <= reg_wr.data[0];
                vdp_pkg::T0XOFFSL: regs.t0x_offs[7:0] <= reg_wr.data;
                vdp_pkg::T0XOFFSH: regs.t0x_offs[8]   <= reg_wr.data[0];
                vdp_pkg::T0YOFFSL: regs.t0y_offs[7:0] <= reg_wr.data;
                vdp_pkg::T0YOFFSH: regs.t0y_offs[8]   <= reg_wr.data[0];
                vdp_pkg::T1XOFFSL: regs.t1x_offs[7:0] <= reg_wr.data;
                vdp_pkg::T1XOFFSH: regs.t1x_offs[8]   <= reg_wr.data[0];
                vdp_pkg::T1YOFFSL: regs.t1y_offs[7:0] <= reg_wr.data;
                vdp_pkg::T1YOFFSH: regs.t1y_offs[8]   <= reg_wr.data[0];
                vdp_pkg::VINTBEGL: regs.vint_beg[7:0] <= reg_wr.data;
                vdp_pkg::VINTBEGH: regs.vint_beg[8]   <= reg_wr.data[0];
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/raster_timer.sv
// Raster timer with pixel and line counters, active window flag and frame interrupt
`timescale 1ns/1ps
`default_nettype none

`include "vdp_defines.svh"

module raster_timer (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire vdp_pkg::video_regs_t regs,
    output vdp_pkg::raster_pos_t      pos,
    output logic                      frame_int
);

    logic [8:0] hcnt_nxt;
    logic [8:0] vcnt_nxt;
    logic       int_hit;
    logic [5:0] int_cnt;

    // Counter values for the next cycle
    always_comb
    begin
        hcnt_nxt = pos.hcnt + 9'd1;
        vcnt_nxt = pos.vcnt;
        if (pos.hcnt == 9'(`VDP_H_TOTAL - 1))
        begin
            hcnt_nxt = 9'd0;
            if (pos.vcnt == 9'(`VDP_V_TOTAL - 1))
                vcnt_nxt = 9'd0;
            else
                vcnt_nxt = pos.vcnt + 9'd1;
        end
    end

    // The interrupt position is matched one cycle early so frame_int rises with it
    assign int_hit = (vcnt_nxt == regs.vint_beg) && (hcnt_nxt == {regs.hint_beg, 1'b0});

    assign frame_int = (int_cnt != 6'd0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pos.hcnt   <= 9'd0;
            pos.vcnt   <= 9'd0;
            // Origin lies inside the visible window
            pos.active <= 1'b1;
            int_cnt    <= 6'd0;
        end
        else
        begin
            pos.hcnt   <= hcnt_nxt;
            pos.vcnt   <= vcnt_nxt;
            pos.active <= (hcnt_nxt < 9'(`VDP_H_ACTIVE)) && (vcnt_nxt < 9'(`VDP_V_ACTIVE));
            if (int_hit)
                int_cnt <= 6'(`VDP_INT_LEN);
            else if (int_cnt != 6'd0)
                int_cnt <= int_cnt - 6'd1;
        end
    end

    a_counters_in_range: assert property (@(posedge clk) disable iff (reset)
        (pos.hcnt < 9'(`VDP_H_TOTAL)) && (pos.vcnt < 9'(`VDP_V_TOTAL)));

endmodule

`default_nettype wire

//--- verilog/layer_scroll.sv
// Layer scroll unit, adds the x and y offsets to the raster position modulo 512
`timescale 1ns/1ps
`default_nettype none

module layer_scroll (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire vdp_pkg::raster_pos_t pos,
    input  wire logic [8:0]           x_offs,
    input  wire logic [8:0]           y_offs,
    input  wire logic [7:0]           page,
    output vdp_pkg::layer_fetch_t     fetch
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fetch <= '0;
        end
        else
        begin
            fetch.page <= page;
            // 9-bit sums wrap around the 512 pixel plane
            fetch.x    <= pos.hcnt + x_offs;
            fetch.y    <= pos.vcnt + y_offs;
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_fetch.sv
// Video fetch stage merging border, mode and both layer results into one pixel request
`timescale 1ns/1ps
`default_nettype none

module video_fetch (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire vdp_pkg::raster_pos_t  pos,
    input  wire vdp_pkg::video_regs_t  regs,
    input  wire vdp_pkg::layer_fetch_t gfx,
    input  wire vdp_pkg::layer_fetch_t tile,
    output vdp_pkg::pix_req_t          pix
);

    // Active flag delayed to match the scroll unit outputs
    logic active_d;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active_d <= 1'b0;
            pix      <= '0;
        end
        else
        begin
            active_d       <= pos.active;
            pix.active     <= active_d;
            pix.border_col <= regs.border;
            pix.mode       <= vdp_pkg::vdp_mode_e'(regs.vconf[1:0]);
            pix.gfx        <= gfx;
            pix.tile       <= tile;
            // Tile plane 0 is enabled by tsconf bit 5
            pix.tile_en    <= active_d & regs.tsconf[5];
        end
    end

    // Tile requests only for raster positions inside the window two stages back
    a_tile_needs_active: assert property (@(posedge clk) disable iff (reset)
        pix.tile_en |-> $past(pos.active, 2));

endmodule

`default_nettype wire

//--- verilog/video_port_top.sv
// Video port front end top level with CPU bridge, registers, raster timer, scroll and fetch
`timescale 1ns/1ps
`default_nettype none

module video_port_top (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             cpu_req,
    input  wire vdp_pkg::cpu_wr_t cpu,
    output logic                  cpu_ack,
    output vdp_pkg::video_regs_t  regs,
    output logic                  frame_int,
    output vdp_pkg::pix_req_t     pix
);

    vdp_pkg::reg_wr_t      reg_wr;
    vdp_pkg::raster_pos_t  pos;
    vdp_pkg::layer_fetch_t gfx_fetch;
    vdp_pkg::layer_fetch_t tile_fetch;

    // ========================================
    // CPU side
    // ========================================
    port_bridge u_bridge (
        .clk     (clk),
        .reset   (reset),
        .cpu_req (cpu_req),
        .cpu     (cpu),
        .cpu_ack (cpu_ack),
        .reg_wr  (reg_wr)
    );

    video_ports u_ports (
        .clk    (clk),
        .reset  (reset),
        .reg_wr (reg_wr),
        .regs   (regs)
    );

    // ========================================
    // Raster side
    // ========================================
    raster_timer u_raster (
        .clk       (clk),
        .reset     (reset),
        .regs      (regs),
        .pos       (pos),
        .frame_int (frame_int)
    );

    // Graphics plane
    layer_scroll u_gfx_scroll (
        .clk    (clk),
        .reset  (reset),
        .pos    (pos),
        .x_offs (regs.gx_offs),
        .y_offs (regs.gy_offs),
        .page   (regs.vpage),
        .fetch  (gfx_fetch)
    );

    // Tile plane 0
    layer_scroll u_tile_scroll (
        .clk    (clk),
        .reset  (reset),
        .pos    (pos),
        .x_offs (regs.t0x_offs),
        .y_offs (regs.t0y_offs),
        .page   (regs.t0gpage),
        .fetch  (tile_fetch)
    );

    video_fetch u_fetch (
        .clk   (clk),
        .reset (reset),
        .pos   (pos),
        .regs  (regs),
        .gfx   (gfx_fetch),
        .tile  (tile_fetch),
        .pix   (pix)
    );

endmodule

`default_nettype wire

//--- sim/video_port_tb.sv
// Video port front end testbench with register write table, raster interrupt and pixel checks
`timescale 1ns/1ps
`default_nettype none

`include "vdp_defines.svh"

module video_port_tb;

    localparam int FRAME      = `VDP_H_TOTAL * `VDP_V_TOTAL;
    localparam int MAX_ROWS   = 64;
    localparam int HS_TIMEOUT = 20;

    logic                 clk;
    logic                 reset;
    logic                 cpu_req;
    vdp_pkg::cpu_wr_t     cpu;
    logic                 cpu_ack;
    vdp_pkg::video_regs_t regs;
    logic                 frame_int;
    vdp_pkg::pix_req_t    pix;

    // Write table, expected registers are filled in by the reference model
    string                row_name [MAX_ROWS];
    logic [15:0]          row_addr [MAX_ROWS];
    logic [7:0]           row_data [MAX_ROWS];
    vdp_pkg::video_regs_t row_exp  [MAX_ROWS];
    int                   n_rows;

    vdp_pkg::video_regs_t model;
    int                   cyc;
    int                   test_errs;
    int                   total_errs;
    int                   n_tests;
    int                   n_bad_tests;

    video_port_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu       (cpu),
        .cpu_ack   (cpu_ack),
        .regs      (regs),
        .frame_int (frame_int),
        .pix       (pix)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycles since reset, equal to the raster position while no frame has wrapped
    always @(posedge clk)
    begin
        if (reset)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // ========================================
    // Reference model
    // ========================================
    function automatic vdp_pkg::video_regs_t reset_values();
        vdp_pkg::video_regs_t r;
        r          = '0;
        r.vpage    = 8'h05;
        r.palsel   = 8'h0F;
        r.hint_beg = 8'd2;
        return r;
    endfunction

    function automatic vdp_pkg::video_regs_t predict_write(input vdp_pkg::video_regs_t prev,
                                                           input logic [15:0] addr,
                                                           input logic [7:0] data);
        vdp_pkg::video_regs_t r;
        r = prev;
        if (addr[7:0] == `VDP_PORT_EXT)
        begin
            case (addr[15:8])
                vdp_pkg::VCONF:    r.vconf         = data;
                vdp_pkg::VPAGE:    r.vpage         = data;
                vdp_pkg::TSCONF:   r.tsconf        = data;
                vdp_pkg::PALSEL:   r.palsel        = data;
                vdp_pkg::BORDER:   r.border        = data;
                vdp_pkg::TMPAGE:   r.tmpage        = data;
                vdp_pkg::T0GPAGE:  r.t0gpage       = data;
                vdp_pkg::T1GPAGE:  r.t1gpage       = data;
                vdp_pkg::SGPAGE:   r.sgpage        = data;
                vdp_pkg::HINTBEG:  r.hint_beg      = data;
                vdp_pkg::GXOFFSL:  r.gx_offs[7:0]  = data;
                vdp_pkg::GXOFFSH:  r.gx_offs[8]    = data[0];
                vdp_pkg::GYOFFSL:  r.gy_offs[7:0]  = data;
                vdp_pkg::GYOFFSH:  r.gy_offs[8]    = data[0];
                vdp_pkg::T0XOFFSL: r.t0x_offs[7:0] = data;
                vdp_pkg::T0XOFFSH: r.t0x_offs[8]   = data[0];
                vdp_pkg::T0YOFFSL: r.t0y_offs[7:0] = data;
                vdp_pkg::T0YOFFSH: r.t0y_offs[8]   = data[0];
                vdp_pkg::T1XOFFSL: r.t1x_offs[7:0] = data;
                vdp_pkg::T1XOFFSH: r.t1x_offs[8]   = data[0];
                vdp_pkg::T1YOFFSL: r.t1y_offs[7:0] = data;
                vdp_pkg::T1YOFFSH: r.t1y_offs[8]   = data[0];
                vdp_pkg::VINTBEGL: r.vint_beg[7:0] = data;
                vdp_pkg::VINTBEGH: r.vint_beg[8]   = data[0];
                default:           r               = prev;
            endcase
        end
        else if (addr == `VDP_PORT_ZPAGE)
            r.vpage = {6'b000001, data[3], 1'b1};
        else if (addr[7:0] == `VDP_PORT_ZBORDER)
            r.border = {5'b11110, data[2:0]};
        return r;
    endfunction

    // Pixel request seen at cycle c comes from the raster position two cycles earlier
    function automatic vdp_pkg::pix_req_t expect_pix(input int c);
        vdp_pkg::pix_req_t p;
        int k;
        int h;
        int v;
        k = (c - 2) % FRAME;
        h = k % `VDP_H_TOTAL;
        v = k / `VDP_H_TOTAL;
        p.active     = (h < `VDP_H_ACTIVE) && (v < `VDP_V_ACTIVE);
        p.border_col = model.border;
        p.mode       = vdp_pkg::vdp_mode_e'(model.vconf[1:0]);
        p.gfx.page   = model.vpage;
        p.gfx.x      = 9'((h + model.gx_offs) % 512);
        p.gfx.y      = 9'((v + model.gy_offs) % 512);
        p.tile_en    = p.active && model.tsconf[5];
        p.tile.page  = model.t0gpage;
        p.tile.x     = 9'((h + model.t0x_offs) % 512);
        p.tile.y     = 9'((v + model.t0y_offs) % 512);
        return p;
    endfunction

    function automatic logic [15:0] ext_addr(input vdp_pkg::vdp_reg_e idx);
        return {idx, `VDP_PORT_EXT};
    endfunction

    // ========================================
    // Compare tasks and bookkeeping
    // ========================================
    task automatic check_regs(input string name, input vdp_pkg::video_regs_t exp,
                              input vdp_pkg::video_regs_t act);
        if (act !== exp)
        begin
            $display("error %s: expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_pix(input string name, input vdp_pkg::pix_req_t exp,
                             input vdp_pkg::pix_req_t act);
        if (act !== exp)
        begin
            $display("error %s at cycle %0d: expected %h actual %h", name, cyc, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("error %s at cycle %0d: expected %b actual %b", name, cyc, exp, act);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (test_errs == 0)
            $display("test %s: ok", name);
        else
        begin
            $display("test %s: %0d mismatches", name, test_errs);
            n_bad_tests++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    task automatic add_row(input string name, input logic [15:0] addr, input logic [7:0] data);
        row_name[n_rows] = name;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_exp[n_rows]  = predict_write(model, addr, data);
        model            = row_exp[n_rows];
        n_rows++;
    endtask

    // ========================================
    // Stimulus tasks
    // ========================================
    // Four-phase write, registers must already hold exp when ack is first seen high
    task automatic cpu_write(input string name, input logic [15:0] addr, input logic [7:0] data,
                             input vdp_pkg::video_regs_t exp);
        int n;
        @(negedge clk);
        check_bit({name, " ack idle"}, 1'b0, cpu_ack);
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu.addr  <= addr;
        cpu.data  <= data;
        n = 0;
        @(negedge clk);
        while (!cpu_ack && n < HS_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!cpu_ack)
        begin
            $display("timeout in %s: ack never rose after req", name);
            test_errs++;
        end
        else
            check_regs({name, " at ack"}, exp, regs);
        @(posedge clk);
        cpu_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (cpu_ack && n < HS_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (cpu_ack)
        begin
            $display("timeout in %s: ack stuck high after req fell", name);
            test_errs++;
        end
    endtask

    task automatic track_write(input string name, input logic [15:0] addr, input logic [7:0] data);
        model = predict_write(model, addr, data);
        cpu_write(name, addr, data, model);
        check_regs(name, model, regs);
    endtask

    task automatic wait_for_pos(input int target);
        int n;
        n = 0;
        @(negedge clk);
        while ((cyc % FRAME) != target && n < 2 * FRAME)
        begin
            @(negedge clk);
            n++;
        end
        if ((cyc % FRAME) != target)
        begin
            $display("timeout: raster never reached position %0d", target);
            test_errs++;
        end
    endtask

    task automatic check_pix_window(input string name, input int len);
        for (int i = 0; i < len; i++)
        begin
            check_pix(name, expect_pix(cyc), pix);
            @(negedge clk);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial
    begin
        vdp_pkg::vdp_reg_e idx;
        int                t;
        int                d;

        cpu_req     = 1'b0;
        cpu         = '0;
        reset       = 1'b1;
        n_rows      = 0;
        test_errs   = 0;
        total_errs  = 0;
        n_tests     = 0;
        n_bad_tests = 0;
        void'($urandom(32'h1febc8b3));

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        model = reset_values();
        check_regs("reset", model, regs);
        check_bit("reset ack", 1'b0, cpu_ack);
        check_bit("reset frame_int", 1'b0, frame_int);
        check_bit("reset pix.active", 1'b0, pix.active);
        check_bit("reset pix.tile_en", 1'b0, pix.tile_en);
        end_test("reset");

        // Every enum index through the window, legacy codes included as unknown indices
        idx = idx.first();
        for (int i = 0; i < idx.num(); i++)
        begin
            add_row({"ext_", idx.name()}, ext_addr(idx), 8'(idx) ^ 8'h3A);
            idx = idx.next();
        end
        add_row("ext_unknown", 16'h08AF, 8'hE7);
        add_row("no_decode", 16'h12AB, 8'h99);
        add_row("zborder", 16'h00FE, 8'hFF);
        add_row("zborder_hi", 16'h5AFE, 8'h02);
        add_row("zpage_bit3", 16'h7FFD, 8'h08);
        add_row("zpage_other", 16'hBFFD, 8'h00);
        add_row("border_over", ext_addr(vdp_pkg::BORDER), 8'h5A);
        add_row("vpage_over", ext_addr(vdp_pkg::VPAGE), 8'h9C);
        idx = idx.first();
        for (int i = 0; i < idx.num(); i++)
        begin
            add_row({"rand_", idx.name()}, ext_addr(idx), 8'($urandom));
            idx = idx.next();
        end

        for (int i = 0; i < n_rows; i++)
        begin
            cpu_write(row_name[i], row_addr[i], row_data[i], row_exp[i]);
            check_regs(row_name[i], row_exp[i], regs);
            end_test(row_name[i]);
        end

        // Frame interrupt at line 261, pixel 160
        track_write("vint_lo", ext_addr(vdp_pkg::VINTBEGL), 8'h05);
        track_write("vint_hi", ext_addr(vdp_pkg::VINTBEGH), 8'h01);
        track_write("hint", ext_addr(vdp_pkg::HINTBEG), 8'h50);
        repeat (`VDP_INT_LEN) @(negedge clk);
        t = model.vint_beg * `VDP_H_TOTAL + model.hint_beg * 2;
        wait_for_pos(t - 4);
        for (int i = 0; i < `VDP_INT_LEN + 8; i++)
        begin
            d = ((cyc % FRAME) - t + FRAME) % FRAME;
            check_bit("frame_int", d < `VDP_INT_LEN, frame_int);
            @(negedge clk);
        end
        end_test("frame_int");

        // Offsets chosen so x wraps past hcnt 16 and y past vcnt 176
        track_write("gx_lo", ext_addr(vdp_pkg::GXOFFSL), 8'hF0);
        track_write("gx_hi", ext_addr(vdp_pkg::GXOFFSH), 8'h01);
        track_write("gy_lo", ext_addr(vdp_pkg::GYOFFSL), 8'h50);
        track_write("gy_hi", ext_addr(vdp_pkg::GYOFFSH), 8'h01);
        track_write("t0x_lo", ext_addr(vdp_pkg::T0XOFFSL), 8'hC3);
        track_write("t0x_hi", ext_addr(vdp_pkg::T0XOFFSH), 8'h00);
        track_write("t0y_lo", ext_addr(vdp_pkg::T0YOFFSL), 8'hFF);
        track_write("t0y_hi", ext_addr(vdp_pkg::T0YOFFSH), 8'h01);
        track_write("vpage", ext_addr(vdp_pkg::VPAGE), 8'h2C);
        track_write("t0gpage", ext_addr(vdp_pkg::T0GPAGE), 8'h81);
        track_write("vconf", ext_addr(vdp_pkg::VCONF), 8'h0E);
        track_write("tsconf_on", ext_addr(vdp_pkg::TSCONF), 8'h20);
        track_write("border", ext_addr(vdp_pkg::BORDER), 8'h3B);
        wait_for_pos(190 * `VDP_H_TOTAL + 240);
        check_pix_window("pix_tile_on", 500);
        end_test("pix_tile_on");

        track_write("tsconf_off", ext_addr(vdp_pkg::TSCONF), 8'hDF);
        wait_for_pos(20 * `VDP_H_TOTAL + 100);
        check_pix_window("pix_tile_off", 200);
        end_test("pix_tile_off");

        $display("tests %0d, failing tests %0d, mismatches %0d", n_tests, n_bad_tests, total_errs);
        if (total_errs == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- video_port_top.f
+incdir+common
common/vdp_pkg.sv
verilog/port_bridge.sv
video_ports/video_ports.sv
verilog/raster_timer.sv
verilog/layer_scroll.sv
verilog/video_fetch.sv
verilog/video_port_top.sv
sim/video_port_tb.sv

//--- Bender.yml
package:
  name: video_port_top

sources:
  - include_dirs:
      - common
    files:
      - common/vdp_pkg.sv
      - verilog/port_bridge.sv
      - video_ports/video_ports.sv
      - verilog/raster_timer.sv
      - verilog/layer_scroll.sv
      - verilog/video_fetch.sv
      - verilog/video_port_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/video_port_tb.sv
